// File: files.f
design/icCachePkg.sv
design/icMemBusPkg.sv
design/icFetchStage.sv
design/icBank.sv
design/icWindowAlign.sv
design/icMissFill.sv
design/icL1Fetch.sv
dv/icMemModel.sv
dv/icL1FetchTb.sv

// File: run.sh
#!/bin/sh
# Build and run the L1 fetch cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module icL1FetchTb -o icL1FetchSim
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

out=$(./obj_dir/icL1FetchSim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "Verification passed"; then
	exit 0
fi
exit 1

// File: dv/icL1FetchTb.sv
`timescale 1ns/1ns

module icL1FetchTb;

	localparam int testCount = 6;
	localparam int fetchesPerTest = 8;
	localparam int worstFill = 20;     // Cycles for two block fills at the longest delay
	localparam int margin = 4;
	localparam int pollLimit = 2 * worstFill;
	localparam int clockPeriod = 4;

	logic clock;
	logic rstN;
	icCachePkg::addrT regInPc;
	logic icInPcHold;
	logic icInPcWxe;
	icMemBusPkg::opmT icInPcOpm;
	icCachePkg::blkDataT memPcData;
	icMemBusPkg::okT memPcOK;
	icCachePkg::windowT regOutPcVal;
	icMemBusPkg::okT regOutPcOK;
	icCachePkg::stepT regOutPcStep;
	icCachePkg::addrT memPcAddr;
	icMemBusPkg::opmT memPcOpm;
	logic [1:0] holdDelay;

	icCachePkg::blkDataT refMem [256];
	logic [31:0] lfsr;
	int errors;
	int testErrors;
	logic sawRdTile;
	icCachePkg::addrT curPc;    // PC of the fetch in progress
	icCachePkg::addrT prevPc;
	string fetchName;

	icL1Fetch UUT (
		.clock(clock), .rstN(rstN), .regInPc(regInPc), .icInPcHold(icInPcHold),
		.icInPcWxe(icInPcWxe), .icInPcOpm(icInPcOpm), .memPcData(memPcData),
		.memPcOK(memPcOK), .regOutPcVal(regOutPcVal), .regOutPcOK(regOutPcOK),
		.regOutPcStep(regOutPcStep), .memPcAddr(memPcAddr), .memPcOpm(memPcOpm)
	);

	icMemModel memModel (
		.clock(clock), .rstN(rstN), .opm(memPcOpm), .addr(memPcAddr),
		.holdDelay(holdDelay), .data(memPcData), .ok(memPcOK)
	);

	initial
	begin
		clock = 1'b0;
		forever
			#(clockPeriod / 2) clock = ~clock;
	end

	initial
	begin
		#(testCount * fetchesPerTest * worstFill * margin * clockPeriod);
		$display("Watchdog expired, the tests did not finish in time");
		$display("Verification failed");
		$finish;
	end

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic takeBits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsrStep(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// A block read belongs to the PC being fetched or to the one before it
	function automatic logic readExpected(input icCachePkg::addrT a);
		icCachePkg::blkAddrT blk;
		blk = a[47:4];
		return (a[3:0] == 4'h0) &&
			((blk == curPc[47:4]) || (blk == curPc[47:4] + 44'd1) ||
			(blk == prevPc[47:4]) || (blk == prevPc[47:4] + 44'd1));
	endfunction

	// Watches the bus and picks a new memory delay per request
	always @(negedge clock)
	begin
		logic [31:0] r;
		assert ((memPcOpm == icMemBusPkg::opmReady) || (memPcOpm == icMemBusPkg::opmRdTile))
		else
		begin
			$display("%s: cache drove operation code %h on the bus", fetchName, memPcOpm);
			errors++;
		end
		if (memPcOpm == icMemBusPkg::opmRdTile)
		begin
			sawRdTile = 1'b1;
			assert (readExpected(memPcAddr))
			else
			begin
				$display("%s: unexpected block read at %h", fetchName, memPcAddr);
				errors++;
			end
			takeBits(2, r);
			holdDelay = r[1:0];
		end
	end

	function automatic logic isWex(input logic [7:0] hb);
		return hb inside {8'hEA, 8'hEB, 8'hEE, 8'hEF, [8'hF4:8'hF7], [8'hFC:8'hFF]};
	endfunction

	function automatic icCachePkg::windowT expWindow(input icCachePkg::addrT pc);
		logic [255:0] pair;
		int b;
		int off;
		b = int'(pc[11:4]);
		off = int'(pc[3:1]) * 16;
		pair = {refMem[(b + 1) % 256], refMem[b]};
		return pair[off +: 96];
	endfunction

	function automatic icCachePkg::stepT expStep(input icCachePkg::windowT w, input logic wxe);
		if (wxe && isWex(w[15:8]))
			return isWex(w[47:40]) ? 3'd6 : 3'd4;
		else if (w[15:8] >= 8'hE0)
			return 3'd2;
		return 3'd1;
	endfunction

	task automatic checkVal(input string name, input logic [95:0] exp, input logic [95:0] act);
		assert (exp == act)
		else
		begin
			$display("[ERROR] %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	// Presents a PC, waits for okOk and checks the window and the step
	task automatic fetchCheck(input string name, input icCachePkg::addrT pc,
		input logic wxe, output int waited);
		@(negedge clock);
		regInPc = pc;
		icInPcWxe = wxe;
		prevPc = curPc;
		curPc = pc;
		fetchName = name;
		waited = 0;
		do
		begin
			@(negedge clock);
			waited++;
		end
		while (regOutPcOK != icMemBusPkg::okOk && waited < pollLimit);
		assert (regOutPcOK == icMemBusPkg::okOk)
		else
		begin
			$display("%s: cache gave no okOk for PC %h within %0d cycles", name, pc, pollLimit);
			errors++;
		end
		checkVal({name, " window"}, expWindow(pc), regOutPcVal);
		checkVal({name, " step"}, 96'(expStep(expWindow(pc), wxe)), 96'(regOutPcStep));
	endtask

	task automatic endTest(input string name);
		$display("test %s: %0d errors", name, errors - testErrors);
		testErrors = errors;
	endtask

	task automatic coldMissTest();
		int waited;
		fetchCheck("coldMiss", 48'h100, 1'b0, waited);
		assert (waited > 1)
		else
		begin
			$display("coldMiss: first PC hit in an empty cache");
			errors++;
		end
		endTest("coldMiss");
	endtask

	task automatic hitTest();
		int waited;
		sawRdTile = 1'b0;
		fetchCheck("hit", 48'h100, 1'b0, waited);
		checkVal("hit latency", 96'd1, 96'(waited));
		assert (!sawRdTile)
		else
		begin
			$display("hit: a memory read was issued for a cached PC");
			errors++;
		end
		endTest("hit");
	endtask

	task automatic crossingTest();
		int waited;
		fetchCheck("cross5", 48'h20A, 1'b0, waited);
		fetchCheck("cross6", 48'h20C, 1'b0, waited);
		fetchCheck("cross7", 48'h20E, 1'b0, waited);
		fetchCheck("crossOdd", 48'h21C, 1'b0, waited);   // Odd block into the next even one
		endTest("crossing");
	endtask

	task automatic stepTest();
		int waited;
		for (int b = 40; b < 44; b++)
		begin
			fetchCheck("stepNoWex", icCachePkg::addrT'(b * 16), 1'b0, waited);
			fetchCheck("stepWex", icCachePkg::addrT'(b * 16), 1'b1, waited);
		end
		endTest("steps");
	endtask

	task automatic flushTest();
		int waited;
		@(negedge clock);
		regInPc = 48'h100;
		icInPcOpm = icMemBusPkg::opmFlushIs;
		@(negedge clock);
		icInPcOpm = icMemBusPkg::opmReady;
		sawRdTile = 1'b0;
		fetchCheck("flush", 48'h100, 1'b0, waited);
		assert (sawRdTile)
		else
		begin
			$display("flush: no block read after FLUSHIS");
			errors++;
		end
		endTest("flush");
	endtask

	task automatic holdTest();
		int waited;
		fetchCheck("holdSetup", 48'h100, 1'b0, waited);
		@(negedge clock);
		icInPcHold = 1'b1;
		regInPc = 48'h900;   // Same bank index as 0x100 with another tag
		repeat (3)
			@(negedge clock);
		checkVal("hold ok", 96'(icMemBusPkg::okOk), 96'(regOutPcOK));
		checkVal("hold window", expWindow(48'h100), regOutPcVal);
		checkVal("hold step", 96'(expStep(expWindow(48'h100), 1'b0)), 96'(regOutPcStep));
		icInPcHold = 1'b0;
		fetchCheck("holdRelease", 48'h900, 1'b0, waited);
		endTest("hold");
	endtask

	initial
	begin
		logic [31:0] r;
		rstN = 1'b0;
		regInPc = '0;
		icInPcHold = 1'b0;
		icInPcWxe = 1'b0;
		icInPcOpm = icMemBusPkg::opmReady;
		holdDelay = 2'd0;
		lfsr = 32'hcfa9;
		errors = 0;
		testErrors = 0;
		sawRdTile = 1'b0;
		curPc = '0;
		prevPc = '0;
		fetchName = "reset";

		for (int i = 0; i < 256; i++)
			for (int j = 0; j < 4; j++)
			begin
				takeBits(32, r);
				refMem[i][j * 32 +: 32] = r;
			end
		// Forced high bytes of words 0 and 2 for the step classes
		refMem[40][15:8] = 8'h12;
		refMem[41][15:8] = 8'hE3;
		refMem[42][15:8] = 8'hEA;
		refMem[42][47:40] = 8'h30;
		refMem[43][15:8] = 8'hFC;
		refMem[43][47:40] = 8'hF5;
		for (int i = 0; i < 256; i++)
			memModel.mem[i] = refMem[i];

		repeat (10)
			@(negedge clock);
		rstN = 1'b1;

		coldMissTest();
		hitTest();
		crossingTest();
		stepTest();
		flushTest();
		holdTest();

		$display("%0d tests run, %0d errors", testCount, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

// File: dv/icMemModel.sv
`timescale 1ns/1ns

module icMemModel (
	input  logic clock,
	input  logic rstN,
	input  icMemBusPkg::opmT opm,
	input  icCachePkg::addrT addr,
	input  logic [1:0] holdDelay,   // okHold cycles for the next read
	output icCachePkg::blkDataT data,
	output icMemBusPkg::okT ok
);

	icCachePkg::blkDataT mem [256];   // Loaded by the testbench
	logic [1:0] phase;
	logic [1:0] count;

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			phase <= 2'd0;
			count <= 2'd0;
			ok <= icMemBusPkg::okReady;
			data <= '0;
		end
		else
		begin
			case (phase)
				2'd0:
				begin
					ok <= icMemBusPkg::okReady;
					if (opm == icMemBusPkg::opmRdTile)
					begin
						data <= mem[addr[11:4]];
						if (holdDelay == 2'd0)
						begin
							ok <= icMemBusPkg::okOk;
							phase <= 2'd2;
						end
						else
						begin
							ok <= icMemBusPkg::okHold;
							count <= holdDelay - 2'd1;
							phase <= 2'd1;
						end
					end
				end
				2'd1:
				begin
					if (count == 2'd0)
					begin
						ok <= icMemBusPkg::okOk;
						phase <= 2'd2;
					end
					else
						count <= count - 2'd1;
				end
				default:
				begin
					// okOk stays until the cache drops the request
					if (opm == icMemBusPkg::opmReady)
					begin
						ok <= icMemBusPkg::okReady;
						phase <= 2'd0;
					end
				end
			endcase
		end
	end

endmodule

// File: design/icL1Fetch.sv
`timescale 1ns/1ns

module icL1Fetch (
	input  logic clock,
	input  logic rstN,
	input  icCachePkg::addrT regInPc,
	input  logic icInPcHold,
	input  logic icInPcWxe,
	input  icMemBusPkg::opmT icInPcOpm,
	input  icCachePkg::blkDataT memPcData,
	input  icMemBusPkg::okT memPcOK,
	output icCachePkg::windowT regOutPcVal,
	output icMemBusPkg::okT regOutPcOK,
	output icCachePkg::stepT regOutPcStep,
	output icCachePkg::addrT memPcAddr,
	output icMemBusPkg::opmT memPcOpm
);

	icCachePkg::addrT inAddr;
	icCachePkg::icBankReq reqA;
	icCachePkg::icBankReq reqB;
	icCachePkg::icBankReq regReqA;    // Requests as read last edge
	icCachePkg::icBankReq regReqB;
	logic flushPulse;
	icCachePkg::blkDataT blkDataA;
	icCachePkg::blkDataT blkDataB;
	icCachePkg::blkAddrT blkTagA;
	icCachePkg::blkAddrT blkTagB;
	logic validA;
	logic validB;
	logic missA;
	logic missB;
	icCachePkg::icFillWrite fillA;
	icCachePkg::icFillWrite fillB;
	icMemBusPkg::icMemReq memReq;

	icFetchStage fetchStage (
		.clock(clock), .rstN(rstN),
		.regInPc(regInPc), .icInPcHold(icInPcHold), .icInPcOpm(icInPcOpm),
		.inAddr(inAddr), .reqA(reqA), .reqB(reqB), .flushPulse(flushPulse)
	);

	// Even blocks
	icBank bankA (
		.clock(clock), .rstN(rstN), .req(reqA), .fill(fillA), .flushPulse(flushPulse),
		.blkData(blkDataA), .blkTag(blkTagA), .blkValid(validA), .regReq(regReqA)
	);

	// Odd blocks
	icBank bankB (
		.clock(clock), .rstN(rstN), .req(reqB), .fill(fillB), .flushPulse(flushPulse),
		.blkData(blkDataB), .blkTag(blkTagB), .blkValid(validB), .regReq(regReqB)
	);

	icWindowAlign aligner (
		.inAddr(inAddr), .reqTagA(regReqA.tag), .reqTagB(regReqB.tag),
		.blkDataA(blkDataA), .blkDataB(blkDataB),
		.blkTagA(blkTagA), .blkTagB(blkTagB),
		.validA(validA), .validB(validB), .icInPcWxe(icInPcWxe),
		.missA(missA), .missB(missB),
		.regOutPcVal(regOutPcVal), .regOutPcStep(regOutPcStep), .regOutPcOK(regOutPcOK)
	);

	icMissFill missFill (
		.clock(clock), .rstN(rstN),
		.missA(missA), .missB(missB), .reqA(regReqA), .reqB(regReqB),
		.memPcOK(memPcOK), .memPcData(memPcData),
		.memReq(memReq), .fillA(fillA), .fillB(fillB)
	);

	assign memPcAddr = memReq.addr;
	assign memPcOpm = memReq.opm;

endmodule

// File: design/icMissFill.sv
`timescale 1ns/1ns

module icMissFill (
	input  logic clock,
	input  logic rstN,
	input  logic missA,
	input  logic missB,
	input  icCachePkg::icBankReq reqA,
	input  icCachePkg::icBankReq reqB,
	input  icMemBusPkg::okT memPcOK,
	input  icCachePkg::blkDataT memPcData,
	output icMemBusPkg::icMemReq memReq,
	output icCachePkg::icFillWrite fillA,
	output icCachePkg::icFillWrite fillB
);

	typedef enum logic [1:0]
	{
		stIdle,
		stReq,
		stDoneWait
	} fillStateT;

	fillStateT state;
	logic selB;     // Block in flight belongs to bank B
	logic issue;
	icCachePkg::icBankReq pickReq;
	icMemBusPkg::opmT reqOpm;
	icCachePkg::addrT reqAddr;
	icCachePkg::idxT fillIdx;
	icCachePkg::blkAddrT fillTag;
	icCachePkg::blkDataT fillData;
	logic fillStrobe;

	// Bank A is served first
	assign pickReq = missA ? reqA : reqB;
	assign issue = (state == stIdle) && (missA || missB) &&
		(memPcOK == icMemBusPkg::okReady);

	always_ff @(posedge clock)
	begin
		if (issue)
		begin
			reqAddr <= {pickReq.tag, 4'b0000};
			fillIdx <= pickReq.idx;
			fillTag <= pickReq.tag;
		end
		if ((state == stReq) && (memPcOK == icMemBusPkg::okOk))
			fillData <= memPcData;
	end

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			state <= stIdle;
			selB <= 1'b0;
			reqOpm <= icMemBusPkg::opmReady;
			fillStrobe <= 1'b0;
		end
		else
		begin
			fillStrobe <= 1'b0;
			case (state)
				stIdle:
				begin
					if (issue)
					begin
						selB <= !missA;
						reqOpm <= icMemBusPkg::opmRdTile;
						state <= stReq;
					end
					else
						reqOpm <= icMemBusPkg::opmReady;
				end
				stReq:
				begin
					// Request stays up through okHold
					if (memPcOK == icMemBusPkg::okOk)
					begin
						reqOpm <= icMemBusPkg::opmReady;
						fillStrobe <= 1'b1;
						state <= stDoneWait;
					end
				end
				default:
				begin
					reqOpm <= icMemBusPkg::opmReady;
					if (memPcOK == icMemBusPkg::okReady)
						state <= stIdle;  // Bus released
				end
			endcase
		end
	end

	always_comb
	begin
		memReq.opm = reqOpm;
		memReq.addr = reqAddr;

		fillA.strobe = fillStrobe && !selB;
		fillA.idx = fillIdx;
		fillA.tag = fillTag;
		fillA.data = fillData;

		fillB.strobe = fillStrobe && selB;
		fillB.idx = fillIdx;
		fillB.tag = fillTag;
		fillB.data = fillData;
	end

endmodule

// File: design/icWindowAlign.sv
`timescale 1ns/1ns

module icWindowAlign (
	input  icCachePkg::addrT inAddr,
	input  icCachePkg::blkAddrT reqTagA,
	input  icCachePkg::blkAddrT reqTagB,
	input  icCachePkg::blkDataT blkDataA,
	input  icCachePkg::blkDataT blkDataB,
	input  icCachePkg::blkAddrT blkTagA,
	input  icCachePkg::blkAddrT blkTagB,
	input  logic validA,
	input  logic validB,
	input  logic icInPcWxe,
	output logic missA,
	output logic missB,
	output icCachePkg::windowT regOutPcVal,
	output icCachePkg::stepT regOutPcStep,
	output icMemBusPkg::okT regOutPcOK
);

	logic [159:0] joined;   // Ten words starting at PC bits 4..3
	logic [1:0] infoA;      // First op
	logic [1:0] infoB;      // Op two words later

	// Returns {wex, twoWord} for the high byte of one 16-bit word
	function automatic logic [1:0] decodeOp(input logic [7:0] hiByte);
		logic twoWord;
		logic wex;
		twoWord = (hiByte[7:5] == 3'b111);    // E0..FF
		casez (hiByte)
			8'b1110_1?1?: wex = 1'b1;       // EA/EB, EE/EF
			8'b1111_?1??: wex = 1'b1;       // F4..F7, FC..FF
			default: wex = 1'b0;
		endcase
		return {wex, twoWord};
	endfunction

	always_comb
	begin
		missA = (blkTagA != reqTagA) || !validA;
		missB = (blkTagB != reqTagB) || !validB;

		case (inAddr[4:3])
			2'b00: joined = {blkDataB[31:0], blkDataA};
			2'b01: joined = {blkDataB[95:0], blkDataA[127:64]};
			2'b10: joined = {blkDataA[31:0], blkDataB};
			default: joined = {blkDataA[95:0], blkDataB[127:64]};
		endcase

		regOutPcVal = joined[{inAddr[2:1], 4'b0000} +: 96];
	end

	always_comb
	begin
		infoA = decodeOp(regOutPcVal[15:8]);
		infoB = decodeOp(regOutPcVal[47:40]);

		// WEX bundle of two or three ops
		if (icInPcWxe && infoA[1])
			regOutPcStep = infoB[1] ? icCachePkg::stepT'(6) : icCachePkg::stepT'(4);
		else if (infoA[0])
			regOutPcStep = icCachePkg::stepT'(2);
		else
			regOutPcStep = icCachePkg::stepT'(1);

		regOutPcOK = (missA || missB) ? icMemBusPkg::okHold : icMemBusPkg::okOk;
	end

endmodule

// File: design/icBank.sv
`timescale 1ns/1ns

module icBank (
	input  logic clock,
	input  logic rstN,
	input  icCachePkg::icBankReq req,
	input  icCachePkg::icFillWrite fill,
	input  logic flushPulse,
	output icCachePkg::blkDataT blkData,
	output icCachePkg::blkAddrT blkTag,
	output logic blkValid,
	output icCachePkg::icBankReq regReq
);

	icCachePkg::blkDataT dataMem [icCachePkg::bankCount];
	icCachePkg::blkAddrT tagMem [icCachePkg::bankCount];
	logic [icCachePkg::bankCount-1:0] validMask;
	logic fillHit;

	// A fill landing on the entry being read is forwarded
	assign fillHit = fill.strobe && (fill.idx == req.idx);

	always_ff @(posedge clock)
	begin
		if (fill.strobe)
		begin
			dataMem[fill.idx] <= fill.data;
			tagMem[fill.idx] <= fill.tag;
		end
		blkData <= fillHit ? fill.data : dataMem[req.idx];
		blkTag <= fillHit ? fill.tag : tagMem[req.idx];
		regReq <= req;      // Requested tag travels with the read
	end

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			validMask <= '0;
			blkValid <= 1'b0;
		end
		else
		begin
			// Flush wins over a fill in the same cycle
			if (flushPulse)
				validMask <= '0;
			else if (fill.strobe)
				validMask[fill.idx] <= 1'b1;
			blkValid <= !flushPulse && (fillHit || validMask[req.idx]);
		end
	end

endmodule

// File: design/icFetchStage.sv
`timescale 1ns/1ns

module icFetchStage (
	input  logic clock,
	input  logic rstN,
	input  icCachePkg::addrT regInPc,
	input  logic icInPcHold,
	input  icMemBusPkg::opmT icInPcOpm,
	output icCachePkg::addrT inAddr,
	output icCachePkg::icBankReq reqA,
	output icCachePkg::icBankReq reqB,
	output logic flushPulse
);

	icCachePkg::addrT nextPc;
	icCachePkg::blkAddrT pcBlk;
	icCachePkg::blkAddrT nextBlk;
	icCachePkg::blkAddrT evenBlk;
	icCachePkg::blkAddrT oddBlk;
	icMemBusPkg::opmT opmQ1;
	icMemBusPkg::opmT opmQ2;
	logic resetFlush;   // One flush right after reset

	always_comb
	begin
		nextPc = icInPcHold ? inAddr : regInPc;
		pcBlk = nextPc[47:icCachePkg::blkOffBits];
		nextBlk = pcBlk + icCachePkg::blkAddrT'(1);

		// Bit 4 is the block parity, so it picks the bank holding the PC
		if (nextPc[4])
		begin
			oddBlk = pcBlk;
			evenBlk = nextBlk;
		end
		else
		begin
			evenBlk = pcBlk;
			oddBlk = nextBlk;
		end

		reqA.idx = evenBlk[6:1];
		reqA.tag = evenBlk;
		reqB.idx = oddBlk[6:1];
		reqB.tag = oddBlk;
	end

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			inAddr <= '0;
			opmQ1 <= icMemBusPkg::opmReady;
			opmQ2 <= icMemBusPkg::opmReady;
			resetFlush <= 1'b1;
		end
		else
		begin
			inAddr <= nextPc;
			opmQ1 <= icInPcOpm;
			opmQ2 <= opmQ1;
			resetFlush <= 1'b0;
		end
	end

	// Rising edge of a FLUSHIS run
	assign flushPulse = resetFlush ||
		((opmQ1 == icMemBusPkg::opmFlushIs) && (opmQ2 != icMemBusPkg::opmFlushIs));

endmodule

// File: design/icMemBusPkg.sv
package icMemBusPkg;

	typedef logic [4:0] opmT;
	typedef logic [1:0] okT;

	// Operation codes towards memory
	localparam opmT opmReady = 5'h00;   // Idle
	localparam opmT opmRdTile = 5'h07;  // Read one 16-byte block
	localparam opmT opmFlushIs = 5'h18; // Invalidate the I-cache

	// Response codes from memory
	localparam okT okReady = 2'b00;
	localparam okT okOk = 2'b01;
	localparam okT okHold = 2'b10;
	localparam okT okFault = 2'b11;     // Never raised by this cache

	// Request on the code bus
	typedef struct packed
	{
		opmT opm;
		icCachePkg::addrT addr;
	} icMemReq;

endpackage

// File: design/icCachePkg.sv
package icCachePkg;

	// Cache geometry
	localparam int bankCount = 64;      // Entries per bank
	localparam int blkOffBits = 4;      // 16-byte blocks

	// Address and data widths
	typedef logic [47:0] addrT;         // Virtual PC
	typedef logic [43:0] blkAddrT;      // PC without the byte offset
	typedef logic [5:0] idxT;           // Block address bits 6..1
	typedef logic [127:0] blkDataT;
	typedef logic [95:0] windowT;       // Up to six 16-bit words
	typedef logic [2:0] stepT;          // In 16-bit words

	// Read request into one bank
	typedef struct packed
	{
		idxT idx;
		blkAddrT tag;
	} icBankReq;

	// Fill store into one bank
	typedef struct packed
	{
		logic strobe;
		idxT idx;
		blkAddrT tag;
		blkDataT data;
	} icFillWrite;

endpackage
